//--- rtl/converter_pkg.sv
package converter_pkg;

  typedef logic [2:0]  bus_code_t;  // Command bus value
  typedef logic [3:0]  leg_t;       // One bit per bridge leg, leg 1 is bit 0
  typedef logic [15:0] duty_t;      // PWM compare value or counter

  typedef enum logic [2:0] {
    MODE_OFF,
    MODE_PLUS,
    MODE_MINUS,
    MODE_BALLAST_P,
    MODE_BALLAST_N
  } bridge_mode_t;

  typedef enum logic [1:0] {CMD_IDLE, CMD_START_ARMED, CMD_FAULT} cmd_state_t;
  typedef enum logic [1:0] {RAMP_IDLE, RAMP_STEP, RAMP_HOLD} ramp_state_t;

  localparam int RAMP_LEVELS = 15;

  // Roughly doubling charge duty per step, last entry is full on
  localparam duty_t DUTY_TABLE [RAMP_LEVELS] = '{
    16'd5,    16'd11,   16'd23,   16'd46,   16'd90,
    16'd174,  16'd338,  16'd654,  16'd1264, 16'd2441,
    16'd4715, 16'd9105, 16'd17580, 16'd33943, 16'd65535
  };

  localparam bus_code_t BUS_PAUSE     = 3'd0;
  localparam bus_code_t BUS_PLUS      = 3'd1;
  localparam bus_code_t BUS_MINUS     = 3'd2;
  localparam bus_code_t BUS_BALLAST_P = 3'd3;
  localparam bus_code_t BUS_BALLAST_N = 3'd4;
  localparam bus_code_t BUS_START     = 3'd5;  // Prefix, a following pause starts the ramp
  localparam bus_code_t BUS_SHUTDOWN  = 3'd6;

endpackage

//--- rtl/converter_ifs.sv
`timescale 1ns/1ps

interface bridge_if;
  import converter_pkg::*;

  logic         cmd_valid;  // One-cycle request for a new pattern
  bridge_mode_t cmd_mode;
  logic         cmd_off;    // One-cycle request for all off now
  logic         drv_busy;   // Dead time in progress

  modport ctrl (output cmd_valid, output cmd_mode, output cmd_off, input drv_busy);
  modport drv  (input cmd_valid, input cmd_mode, input cmd_off, output drv_busy);
endinterface

interface ramp_if;
  logic ramp_go;
  logic ramp_abort;
  logic ramp_busy;
  logic ramp_done;  // Pulses only on a normal end of the ramp

  modport ctrl (output ramp_go, output ramp_abort, input ramp_busy, input ramp_done);
  modport seq  (input ramp_go, input ramp_abort, output ramp_busy, output ramp_done);
endinterface

//--- rtl/input_filter.sv
`timescale 1ns/1ps

module input_filter #(
  parameter int FILTER_WIDTH = 8,
  parameter bit INVERT       = 1'b0
) (
  input  logic clk,
  input  logic rstn,
  input  logic i_pin,
  output logic o_level
);

  logic [FILTER_WIDTH-1:0] samples;  // Newest sample in bit 0
  logic                    pin_s;

  assign pin_s = INVERT ? ~i_pin : i_pin;  // Active-low pins become active high

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      samples <= '0;
      o_level <= 1'b0;
    end else begin
      samples <= {samples[FILTER_WIDTH-2:0], pin_s};
      if (&samples) begin
        o_level <= 1'b1;
      end else if (~|samples) begin
        o_level <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     i_strobe,
  input  converter_pkg::bus_code_t i_bus,
  input  logic                     i_fault,
  bridge_if.ctrl                   br,
  ramp_if.ctrl                     rp,
  output logic                     o_fan,
  output logic                     o_idle
);
  import converter_pkg::*;

  cmd_state_t state;
  logic       strobe_q;
  logic       strobe_fall;
  logic       ready;      // Soft start finished, bridge commands allowed
  logic       bridge_ok;

  function automatic bridge_mode_t mode_of(bus_code_t code);
    case (code)
      BUS_PLUS:      return MODE_PLUS;
      BUS_MINUS:     return MODE_MINUS;
      BUS_BALLAST_P: return MODE_BALLAST_P;
      BUS_BALLAST_N: return MODE_BALLAST_N;
      default:       return MODE_OFF;
    endcase
  endfunction

  assign strobe_fall = strobe_q & ~i_strobe;
  assign bridge_ok   = ready & ~rp.ramp_busy;
  assign o_idle      = (state == CMD_IDLE);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state         <= CMD_IDLE;
      strobe_q      <= 1'b0;
      ready         <= 1'b0;
      o_fan         <= 1'b0;
      br.cmd_valid  <= 1'b0;
      br.cmd_mode   <= MODE_OFF;
      br.cmd_off    <= 1'b0;
      rp.ramp_go    <= 1'b0;
      rp.ramp_abort <= 1'b0;
    end else begin
      strobe_q      <= i_strobe;
      br.cmd_valid  <= 1'b0;  // Requests are single pulses
      br.cmd_off    <= 1'b0;
      rp.ramp_go    <= 1'b0;
      rp.ramp_abort <= 1'b0;
      if (rp.ramp_done) begin
        ready <= 1'b1;
      end
      if (i_fault) begin
        state <= CMD_FAULT;  // Terminal, left only by reset
        o_fan <= 1'b1;
        ready <= 1'b0;
      end else if (strobe_fall && !br.drv_busy) begin  // Strobes during dead time are lost
        case (state)
          CMD_IDLE: begin
            case (i_bus)
              BUS_PAUSE: begin
                if (!rp.ramp_busy) begin
                  br.cmd_off <= 1'b1;
                end
              end
              BUS_PLUS, BUS_MINUS, BUS_BALLAST_P, BUS_BALLAST_N: begin
                if (bridge_ok) begin
                  br.cmd_valid <= 1'b1;
                  br.cmd_mode  <= mode_of(i_bus);
                end
              end
              BUS_START: begin
                if (!rp.ramp_busy) begin
                  state <= CMD_START_ARMED;
                end
              end
              BUS_SHUTDOWN: begin
                rp.ramp_abort <= 1'b1;
                br.cmd_off    <= 1'b1;
                o_fan         <= 1'b0;
                ready         <= 1'b0;
              end
              default: ;  // Code 7 has no function
            endcase
          end
          CMD_START_ARMED: begin
            if (i_bus == BUS_PAUSE) begin
              rp.ramp_go <= 1'b1;
              br.cmd_off <= 1'b1;
              o_fan      <= 1'b1;
            end
            state <= CMD_IDLE;  // Any other code disarms
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- rtl/bridge_driver.sv
`timescale 1ns/1ps

module bridge_driver #(
  parameter int WAITSTATES = 4
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                i_fault,
  bridge_if.drv               br,
  output converter_pkg::leg_t o_top,
  output converter_pkg::leg_t o_bot,
  output logic                o_plus,
  output logic                o_minus,
  output logic                o_pause_p,
  output logic                o_pause_n
);
  import converter_pkg::*;

  localparam int CNT_W = (WAITSTATES > 0) ? $clog2(WAITSTATES + 1) : 1;

  bridge_mode_t     pend_mode;
  logic [CNT_W-1:0] ws_cnt;
  logic             busy;
  leg_t             nxt_top;
  leg_t             nxt_bot;
  logic [3:0]       nxt_sign;
  logic [3:0]       sign;      // {pause_n, pause_p, minus, plus}

  assign br.drv_busy = busy;
  assign {o_pause_n, o_pause_p, o_minus, o_plus} = sign;

  always_comb begin
    nxt_top  = '0;
    nxt_bot  = '0;
    nxt_sign = '0;
    case (pend_mode)
      MODE_PLUS: begin
        nxt_top  = 4'b0001;
        nxt_bot  = 4'b0010;
        nxt_sign = 4'b0001;
      end
      MODE_MINUS: begin
        nxt_top  = 4'b0010;
        nxt_bot  = 4'b0001;
        nxt_sign = 4'b0010;
      end
      MODE_BALLAST_P: begin
        nxt_top  = 4'b0100;
        nxt_bot  = 4'b1000;
        nxt_sign = 4'b0100;
      end
      MODE_BALLAST_N: begin
        nxt_top  = 4'b1000;
        nxt_bot  = 4'b0100;
        nxt_sign = 4'b1000;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pend_mode <= MODE_OFF;
    end else if (i_fault || br.cmd_off) begin
      pend_mode <= MODE_OFF;
    end else if (br.cmd_valid) begin
      pend_mode <= br.cmd_mode;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy   <= 1'b0;
      ws_cnt <= '0;
      o_top  <= '0;
      o_bot  <= '0;
      sign   <= '0;
    end else if (i_fault || br.cmd_off) begin  // Drop pending pattern too
      busy   <= 1'b0;
      ws_cnt <= '0;
      o_top  <= '0;
      o_bot  <= '0;
      sign   <= '0;
    end else if (br.cmd_valid) begin
      busy   <= 1'b1;  // All off during dead time
      ws_cnt <= CNT_W'(WAITSTATES);
      o_top  <= '0;
      o_bot  <= '0;
      sign   <= '0;
    end else if (busy) begin
      if (ws_cnt == '0) begin
        busy  <= 1'b0;
        o_top <= nxt_top;
        o_bot <= nxt_bot;
        sign  <= nxt_sign;
      end else begin
        ws_cnt <= ws_cnt - 1'b1;
      end
    end
  end

endmodule

//--- rtl/soft_start.sv
`timescale 1ns/1ps

module soft_start #(
  parameter int STEP_CYCLES = 50_000_000
) (
  input  logic clk,
  input  logic rstn,
  input  logic i_fault,
  ramp_if.seq  rp,
  output logic o_charge,
  output logic o_ch,
  output logic o_st
);
  import converter_pkg::*;

  localparam int TMR_W = (STEP_CYCLES > 0) ? $clog2(STEP_CYCLES + 1) : 1;

  ramp_state_t      state;
  logic [TMR_W-1:0] step_tmr;
  logic [3:0]       level_idx;  // Index into the duty table
  duty_t            level;
  duty_t            pwm_cnt;

  assign rp.ramp_busy = (state != RAMP_IDLE);
  assign o_ch = o_charge & ((pwm_cnt < level) | (&level));  // Full level stays on

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= RAMP_IDLE;
      step_tmr     <= '0;
      level_idx    <= '0;
      level        <= '0;
      o_charge     <= 1'b0;
      o_st         <= 1'b0;
      rp.ramp_done <= 1'b0;
    end else begin
      rp.ramp_done <= 1'b0;
      if (i_fault || rp.ramp_abort) begin
        state    <= RAMP_IDLE;
        step_tmr <= '0;
        level    <= '0;
        o_charge <= 1'b0;
        o_st     <= 1'b0;
      end else begin
        case (state)
          RAMP_IDLE: begin
            if (rp.ramp_go) begin
              state     <= RAMP_STEP;
              step_tmr  <= TMR_W'(STEP_CYCLES);
              level_idx <= '0;
              level     <= DUTY_TABLE[0];
              o_charge  <= 1'b1;
              o_st      <= 1'b0;
            end
          end
          RAMP_STEP: begin
            if (step_tmr != '0) begin
              step_tmr <= step_tmr - 1'b1;
            end else if (level_idx == 4'(RAMP_LEVELS - 1)) begin
              state    <= RAMP_HOLD;  // Contactor closes, one more step
              step_tmr <= TMR_W'(STEP_CYCLES);
              o_st     <= 1'b1;
            end else begin
              step_tmr  <= TMR_W'(STEP_CYCLES);
              level_idx <= level_idx + 1'b1;
              level     <= DUTY_TABLE[level_idx + 1'b1];
            end
          end
          RAMP_HOLD: begin
            if (step_tmr != '0) begin
              step_tmr <= step_tmr - 1'b1;
            end else begin
              state        <= RAMP_IDLE;
              level        <= '0;
              o_charge     <= 1'b0;
              rp.ramp_done <= 1'b1;
            end
          end
          default: state <= RAMP_IDLE;
        endcase
      end
    end
  end

endmodule

//--- rtl/fault_monitor.sv
`timescale 1ns/1ps

module fault_monitor (
  input  logic                clk,
  input  logic                rstn,
  input  converter_pkg::leg_t i_err_dr,
  input  logic                i_err_u,
  input  logic                i_err_i,
  input  logic                i_bt,
  input  logic                i_stop_k,
  output logic                o_fault,
  output logic                o_break,
  output converter_pkg::leg_t o_erbd,
  output logic                o_avv,
  output logic                o_avi,
  output logic                o_td,
  output logic                o_stop
);

  logic fault_now;

  assign fault_now = |{i_err_dr, i_err_u, i_err_i, i_bt, i_stop_k};  // Eight sources

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_fault <= 1'b0;
      o_break <= 1'b0;
      o_erbd  <= '0;
      o_avv   <= 1'b0;
      o_avi   <= 1'b0;
      o_td    <= 1'b0;
      o_stop  <= 1'b0;
    end else begin
      o_fault <= fault_now;
      o_break <= o_break | fault_now;  // Flags are sticky
      o_erbd  <= o_erbd | i_err_dr;
      o_avv   <= o_avv | i_err_u;
      o_avi   <= o_avi | i_err_i;
      o_td    <= o_td | i_bt;
      o_stop  <= o_stop | i_stop_k;
    end
  end

endmodule

//--- rtl/converter_top.sv
`timescale 1ns/1ps

module converter_top #(
  parameter int FILTER_WIDTH = 8,
  parameter int WAITSTATES   = 4,
  parameter int STEP_CYCLES  = 50_000_000
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     i_strobe,
  input  converter_pkg::bus_code_t i_bus,
  input  converter_pkg::leg_t      i_err_dr_n,
  input  logic                     i_err_u_n,
  input  logic                     i_err_i_n,
  input  logic                     i_stop_n,
  input  logic                     i_bt,
  output converter_pkg::leg_t      o_top,
  output converter_pkg::leg_t      o_bot,
  output logic                     o_plus,
  output logic                     o_minus,
  output logic                     o_pause_p,
  output logic                     o_pause_n,
  output logic                     o_charge,
  output logic                     o_ch,
  output logic                     o_st,
  output logic                     o_fan,
  output logic                     o_break,
  output converter_pkg::leg_t      o_erbd,
  output logic                     o_avv,
  output logic                     o_avi,
  output logic                     o_td,
  output logic                     o_stop,
  output logic                     o_idle
);
  import converter_pkg::*;

  localparam int                N_PINS   = 12;
  localparam logic [N_PINS-1:0] INV_MASK = 12'h7F0;  // Error and stop pins are active low

  logic [N_PINS-1:0] pin_raw;
  logic [N_PINS-1:0] pin_flt;
  bus_code_t         bus_f;
  leg_t              err_dr_f;
  logic              fault_any;

  assign pin_raw  = {i_bt, i_stop_n, i_err_i_n, i_err_u_n, i_err_dr_n, i_bus, i_strobe};
  assign bus_f    = pin_flt[3:1];
  assign err_dr_f = pin_flt[7:4];

  for (genvar i = 0; i < N_PINS; i++) begin : g_filter
    input_filter #(
      .FILTER_WIDTH(FILTER_WIDTH),
      .INVERT      (INV_MASK[i])
    ) u_filter (
      .clk    (clk),
      .rstn   (rstn),
      .i_pin  (pin_raw[i]),
      .o_level(pin_flt[i])
    );
  end

  bridge_if br_if ();
  ramp_if   rp_if ();

  command_decoder u_command_decoder (
    .clk     (clk),
    .rstn    (rstn),
    .i_strobe(pin_flt[0]),
    .i_bus   (bus_f),
    .i_fault (fault_any),
    .br      (br_if.ctrl),
    .rp      (rp_if.ctrl),
    .o_fan   (o_fan),
    .o_idle  (o_idle)
  );

  bridge_driver #(
    .WAITSTATES(WAITSTATES)
  ) u_bridge_driver (
    .clk      (clk),
    .rstn     (rstn),
    .i_fault  (fault_any),
    .br       (br_if.drv),
    .o_top    (o_top),
    .o_bot    (o_bot),
    .o_plus   (o_plus),
    .o_minus  (o_minus),
    .o_pause_p(o_pause_p),
    .o_pause_n(o_pause_n)
  );

  soft_start #(
    .STEP_CYCLES(STEP_CYCLES)
  ) u_soft_start (
    .clk     (clk),
    .rstn    (rstn),
    .i_fault (fault_any),
    .rp      (rp_if.seq),
    .o_charge(o_charge),
    .o_ch    (o_ch),
    .o_st    (o_st)
  );

  fault_monitor u_fault_monitor (
    .clk     (clk),
    .rstn    (rstn),
    .i_err_dr(err_dr_f),
    .i_err_u (pin_flt[8]),
    .i_err_i (pin_flt[9]),
    .i_bt    (pin_flt[11]),
    .i_stop_k(pin_flt[10]),
    .o_fault (fault_any),
    .o_break (o_break),
    .o_erbd  (o_erbd),
    .o_avv   (o_avv),
    .o_avi   (o_avi),
    .o_td    (o_td),
    .o_stop  (o_stop)
  );

endmodule

//--- testbench/converter_assertions.sv
`timescale 1ns/1ps

module converter_assertions (
  input logic                clk,
  input logic                rstn,
  input converter_pkg::leg_t i_top,
  input converter_pkg::leg_t i_bot,
  input logic                i_busy,
  input logic [3:0]          i_sign
);

  int fail_count = 0;  // Read by the testbench at the end

  no_shoot_through: assert property (@(posedge clk) disable iff (!rstn)
    (i_top & i_bot) == 4'b0000)
    else begin
      fail_count++;
      $error("Top and bottom switch of one leg are on together");
    end

  off_in_dead_time: assert property (@(posedge clk) disable iff (!rstn)
    i_busy |-> (i_top == 4'b0000 && i_bot == 4'b0000))
    else begin
      fail_count++;
      $error("Bridge legs are on during dead time");
    end

  one_sign_at_most: assert property (@(posedge clk) disable iff (!rstn) $onehot0(i_sign))
    else begin
      fail_count++;
      $error("More than one sign output is on");
    end

endmodule

//--- testbench/converter_monitor.sv
`timescale 1ns/1ps

module converter_monitor (
  input  logic                clk,
  input  logic                i_arm,     // Starts a new case window
  input  logic                i_check,
  input  int                  i_case,
  input  logic [26:0]         i_expect,
  input  converter_pkg::leg_t i_top,
  input  converter_pkg::leg_t i_bot,
  input  logic                i_plus,
  input  logic                i_minus,
  input  logic                i_pause_p,
  input  logic                i_pause_n,
  input  logic                i_charge,
  input  logic                i_ch,
  input  logic                i_st,
  input  logic                i_fan,
  input  logic                i_break,
  input  converter_pkg::leg_t i_erbd,
  input  logic                i_avv,
  input  logic                i_avi,
  input  logic                i_td,
  input  logic                i_stop,
  input  logic                i_idle,
  output int                  o_cases,
  output int                  o_errors
);

  int         cases = 0;
  int         errors = 0;
  int         case_errs;
  logic       charge_seen = 1'b0;  // o_charge was high in this case
  logic [3:0] sign;
  logic [7:0] flags;

  assign sign     = {i_pause_n, i_pause_p, i_minus, i_plus};
  assign flags    = {i_td, i_stop, i_avi, i_avv, i_erbd};
  assign o_cases  = cases;
  assign o_errors = errors;

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("ERROR case %0d: %s expected 0x%h, actual 0x%h", i_case, name, exp, act);
      case_errs++;
    end
  endtask

  always @(negedge clk) begin
    if (i_arm) begin
      charge_seen <= 1'b0;
    end else if (i_charge) begin
      charge_seen <= 1'b1;
    end
  end

  // Expected layout {flags, seen, ch, charge, idle, break, fan, st, sign, bot, top}
  always @(negedge clk) begin
    if (i_check) begin
      case_errs = 0;
      check_value("o_top", 8'(i_expect[3:0]), 8'(i_top));
      check_value("o_bot", 8'(i_expect[7:4]), 8'(i_bot));
      check_value("sign outputs", 8'(i_expect[11:8]), 8'(sign));
      check_value("o_st", 8'(i_expect[12]), 8'(i_st));
      check_value("o_fan", 8'(i_expect[13]), 8'(i_fan));
      check_value("o_break", 8'(i_expect[14]), 8'(i_break));
      check_value("o_idle", 8'(i_expect[15]), 8'(i_idle));
      check_value("o_charge", 8'(i_expect[16]), 8'(i_charge));
      check_value("o_ch", 8'(i_expect[17]), 8'(i_ch));
      check_value("o_charge seen high", 8'(i_expect[18]), 8'(charge_seen));
      check_value("fault flags", i_expect[26:19], flags);
      if (case_errs == 0) begin
        $display("case %0d: ok", i_case);
      end else begin
        $display("case %0d: %0d mismatches", i_case, case_errs);
      end
      cases  <= cases + 1;
      errors <= errors + case_errs;
    end
  end

endmodule

//--- testbench/tb_converter_top.sv
`timescale 1ns/1ps

module tb_converter_top;
  import converter_pkg::*;

  localparam int FILTER_WIDTH = 4;
  localparam int WAITSTATES   = 4;
  localparam int STEP_CYCLES  = 8;
  localparam int FIELDS       = 13;  // Columns per case line
  localparam int MAX_CASES    = 32;
  localparam int HOLD_CYCLES  = 2 * FILTER_WIDTH + 2;
  localparam int SHORT_SETTLE = 2 * (FILTER_WIDTH + 2) + WAITSTATES + 4;
  localparam int RAMP_SETTLE  = 16 * (STEP_CYCLES + 1) + 20;

  logic        clk;
  logic        rstn;
  logic        i_strobe;
  bus_code_t   i_bus;
  leg_t        i_err_dr_n;
  logic        i_err_u_n;
  logic        i_err_i_n;
  logic        i_stop_n;
  logic        i_bt;
  leg_t        o_top;
  leg_t        o_bot;
  logic        o_plus;
  logic        o_minus;
  logic        o_pause_p;
  logic        o_pause_n;
  logic        o_charge;
  logic        o_ch;
  logic        o_st;
  logic        o_fan;
  logic        o_break;
  leg_t        o_erbd;
  logic        o_avv;
  logic        o_avi;
  logic        o_td;
  logic        o_stop;
  logic        o_idle;
  logic        arm;
  logic        check;
  int          case_id;
  logic [26:0] expect_bits;
  int          done_cases;
  int          mismatches;
  int          cycles = 0;
  int          limit = 0;   // Set once the case file is read
  logic [7:0]  case_mem [FIELDS*MAX_CASES];

  converter_top #(
    .FILTER_WIDTH(FILTER_WIDTH),
    .WAITSTATES  (WAITSTATES),
    .STEP_CYCLES (STEP_CYCLES)
  ) u_converter_top (.*);

  converter_monitor u_monitor (
    .clk      (clk),
    .i_arm    (arm),
    .i_check  (check),
    .i_case   (case_id),
    .i_expect (expect_bits),
    .i_top    (o_top),
    .i_bot    (o_bot),
    .i_plus   (o_plus),
    .i_minus  (o_minus),
    .i_pause_p(o_pause_p),
    .i_pause_n(o_pause_n),
    .i_charge (o_charge),
    .i_ch     (o_ch),
    .i_st     (o_st),
    .i_fan    (o_fan),
    .i_break  (o_break),
    .i_erbd   (o_erbd),
    .i_avv    (o_avv),
    .i_avi    (o_avi),
    .i_td     (o_td),
    .i_stop   (o_stop),
    .i_idle   (o_idle),
    .o_cases  (done_cases),
    .o_errors (mismatches)
  );

  bind bridge_driver converter_assertions u_bridge_assertions (
    .clk   (clk),
    .rstn  (rstn),
    .i_top (o_top),
    .i_bot (o_bot),
    .i_busy(busy),
    .i_sign(sign)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, the cases did not finish", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic int case_length(input logic [7:0] kind);
    if (kind == 8'd2) begin
      return SHORT_SETTLE + 4;
    end
    return 3 * HOLD_CYCLES + ((kind == 8'd1) ? RAMP_SETTLE : SHORT_SETTLE) + 4;
  endfunction

  // Packs the expected columns in the order the monitor unpacks them
  function automatic logic [26:0] pack_expect(input int base);
    return {case_mem[base+12], case_mem[base+11][0], case_mem[base+10][0],
            case_mem[base+9][0], case_mem[base+8][0], case_mem[base+7][0],
            case_mem[base+6][0], case_mem[base+5][0], case_mem[base+4][3:0],
            case_mem[base+3][3:0], case_mem[base+2][3:0]};
  endfunction

  task automatic send_command(input bus_code_t code);
    i_bus <= code;  // Bus settles before the strobe rises
    repeat (HOLD_CYCLES) @(negedge clk);
    i_strobe <= 1'b1;
    repeat (HOLD_CYCLES) @(negedge clk);
    i_strobe <= 1'b0;
    repeat (HOLD_CYCLES) @(negedge clk);
  endtask

  task automatic apply_faults(input logic [7:0] mask);
    i_err_dr_n <= ~mask[3:0];
    i_err_u_n  <= ~mask[4];
    i_err_i_n  <= ~mask[5];
    i_stop_n   <= ~mask[6];
    i_bt       <= mask[7];  // Only active-high fault pin
  endtask

  task automatic run_case(input int idx);
    logic [7:0] kind;
    logic [7:0] code;
    int         base;
    base = idx * FIELDS;
    kind = case_mem[base];
    code = case_mem[base+1];
    @(negedge clk);
    arm <= 1'b1;
    @(negedge clk);
    arm <= 1'b0;
    if (kind == 8'd2) begin
      apply_faults(code);
      repeat (SHORT_SETTLE) @(negedge clk);
    end else begin
      send_command(code[2:0]);
      repeat ((kind == 8'd1) ? RAMP_SETTLE : SHORT_SETTLE) @(negedge clk);
    end
    case_id     <= idx + 1;
    expect_bits <= pack_expect(base);
    check       <= 1'b1;
    @(negedge clk);
    check <= 1'b0;
  endtask

  initial begin
    int n_cases;
    int total;
    int assert_fails;
    int i;
    rstn        = 1'b0;
    i_strobe    = 1'b0;
    i_bus       = BUS_PAUSE;
    i_err_dr_n  = 4'hF;
    i_err_u_n   = 1'b1;
    i_err_i_n   = 1'b1;
    i_stop_n    = 1'b1;
    i_bt        = 1'b0;
    arm         = 1'b0;
    check       = 1'b0;
    case_id     = 0;
    expect_bits = '0;
    for (i = 0; i < FIELDS * MAX_CASES; i++) begin
      case_mem[i] = 8'hFF;  // Kind FF ends the case list
    end
    $readmemh("testbench/converter_cases.txt", case_mem);
    n_cases = 0;
    total   = 12;
    while (n_cases < MAX_CASES && case_mem[n_cases*FIELDS] != 8'hFF) begin
      total += case_length(case_mem[n_cases*FIELDS]);
      n_cases++;
    end
    limit = total + 200;
    repeat (10) @(negedge clk);
    rstn <= 1'b1;
    repeat (2) @(negedge clk);
    for (i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    wait (done_cases == n_cases);
    @(negedge clk);
    assert_fails = u_converter_top.u_bridge_driver.u_bridge_assertions.fail_count;
    $display("Cases run: %0d, mismatches: %0d, assertion failures: %0d",
             done_cases, mismatches, assert_fails);
    if (n_cases > 0 && mismatches == 0 && assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- converter_top.f
rtl/converter_pkg.sv
rtl/converter_ifs.sv
rtl/input_filter.sv
rtl/command_decoder.sv
rtl/bridge_driver.sv
rtl/soft_start.sv
rtl/fault_monitor.sv
rtl/converter_top.sv
testbench/converter_assertions.sv
testbench/converter_monitor.sv
testbench/tb_converter_top.sv

//--- Makefile
TOP := tb_converter_top

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f converter_top.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- testbench/converter_cases.txt
// kind code top bot sign st fan brk idle charge ch seen flags
// kind 0 strobes code, 1 strobes code and waits a full ramp, 2 drives code as a fault mask
// sign is {pause_n, pause_p, minus, plus}, flags is {td, stop, avi, avv, erbd}
0 1 0 0 0 0 0 0 1 0 0 0 00
0 2 0 0 0 0 0 0 1 0 0 0 00
0 3 0 0 0 0 0 0 1 0 0 0 00
0 4 0 0 0 0 0 0 1 0 0 0 00
0 5 0 0 0 0 0 0 0 0 0 0 00
1 0 0 0 0 1 1 0 1 0 0 1 00
0 1 1 2 1 1 1 0 1 0 0 0 00
0 0 0 0 0 1 1 0 1 0 0 0 00
0 2 2 1 2 1 1 0 1 0 0 0 00
0 3 4 8 4 1 1 0 1 0 0 0 00
0 4 8 4 8 1 1 0 1 0 0 0 00
0 5 8 4 8 1 1 0 0 0 0 0 00
0 3 8 4 8 1 1 0 1 0 0 0 00
0 1 1 2 1 1 1 0 1 0 0 0 00
0 6 0 0 0 0 0 0 1 0 0 0 00
0 2 0 0 0 0 0 0 1 0 0 0 00
0 5 0 0 0 0 0 0 0 0 0 0 00
1 0 0 0 0 1 1 0 1 0 0 1 00
0 1 1 2 1 1 1 0 1 0 0 0 00
2 20 0 0 0 0 1 1 0 0 0 0 20
0 5 0 0 0 0 1 1 0 0 0 0 20
1 0 0 0 0 0 1 1 0 0 0 0 20
0 1 0 0 0 0 1 1 0 0 0 0 20
